/* Bender.yml */
package:
  name: neo_video

sources:
  - neoPkg.sv
  - cpuBus.sv
  - sysLatch.sv
  - palRam.sv
  - colorOut.sv
  - serVideo.sv
  - neoVideo.sv
  - target: simulation
    files:
      - tbNeoVideo.sv

/* colorOut.sv */
`timescale 1ns/10ps

module colorOut (
	input logic CLK_24M,
	input logic rst,
	input logic pixValid,
	input logic [neoPkg::PalIdxBits-1:0] pixIndex,
	input logic shadow,
	input logic palBank,
	output logic vidEn,
	output logic [neoPkg::PalAddrBits-1:0] vidAddr,
	input neoPkg::PalWord vidRdata,
	output logic colValid,
	output logic [neoPkg::ColorBits-1:0] colR,
	output logic [neoPkg::ColorBits-1:0] colG,
	output logic [neoPkg::ColorBits-1:0] colB
);

	logic s1Valid;
	logic [neoPkg::PalIdxBits-1:0] s1Idx;
	logic s1Bank;
	logic s1Shadow;
	logic s2Valid;
	logic s2Shadow;

	// Upper part, lsb, inverted dark, zero; shadow halves it
	function automatic logic [neoPkg::ColorBits-1:0] level(
		input logic [3:0] upper,
		input logic lsb,
		input logic dark,
		input logic shade
	);
		logic [neoPkg::ColorBits-1:0] lvl;
		lvl = {upper, lsb, ~dark, 1'b0};
		return shade ? (lvl >> 1) : lvl;
	endfunction

	// Stage one holds the accepted pixel and drives the palette read
	always_ff @(posedge CLK_24M) begin
		if (rst) begin
			s1Valid <= 1'b0;
			s2Valid <= 1'b0;
		end else begin
			s1Valid <= pixValid;
			s2Valid <= s1Valid;
		end
	end

	always_ff @(posedge CLK_24M) begin
		s1Idx <= pixIndex;
		s1Bank <= palBank;
		s1Shadow <= shadow;
		s2Shadow <= s1Shadow;
	end

	assign vidEn = s1Valid;
	assign vidAddr = {s1Bank, s1Idx};

	// Stage two converts the word as it leaves the RAM
	assign colValid = s2Valid;
	assign colR = level(vidRdata.fields.r, vidRdata.fields.rLsb, vidRdata.fields.dark, s2Shadow);
	assign colG = level(vidRdata.fields.g, vidRdata.fields.gLsb, vidRdata.fields.dark, s2Shadow);
	assign colB = level(vidRdata.fields.b, vidRdata.fields.bLsb, vidRdata.fields.dark, s2Shadow);

endmodule

/* cpuBus.sv */
`timescale 1ns/10ps

module cpuBus (
	input logic CLK_24M,
	input logic rst,
	input logic cpuReq,
	input logic cpuWe,
	input logic [23:1] cpuAddr,
	input logic [1:0] cpuBe,
	input logic [15:0] cpuWdata,
	output logic cpuAck,
	output logic [15:0] cpuRdata,
	output logic palCpuEn,
	output logic palCpuWe,
	output logic [neoPkg::PalAddrBits-1:0] palCpuAddr,
	output logic [1:0] palCpuBe,
	output neoPkg::PalWord palCpuWdata,
	output logic latchWe,
	output logic [3:0] latchAddr,
	input neoPkg::PalWord palCpuRdata,
	input logic palBank
);

	logic palHit;
	logic latchHit;
	logic palRd;

	// Zone decode, as C1 does it
	assign palHit = (cpuAddr[23:20] == neoPkg::PalZoneBase);
	assign latchHit = (cpuAddr[23:5] == neoPkg::LatchZoneBase);

	// Palette port, bank from the live latch bit
	assign palCpuEn = cpuReq & palHit;
	assign palCpuWe = cpuReq & palHit & cpuWe;
	assign palCpuAddr = {palBank, cpuAddr[neoPkg::PalIdxBits:1]};
	assign palCpuBe = cpuBe;
	assign palCpuWdata.raw = cpuWdata;

	// Address-only write, the data bus is ignored
	assign latchWe = cpuReq & cpuWe & latchHit;
	assign latchAddr = cpuAddr[4:1];

	// Fixed one-cycle acknowledge
	always_ff @(posedge CLK_24M) begin
		if (rst) begin
			cpuAck <= 1'b0;
			palRd <= 1'b0;
		end else begin
			cpuAck <= cpuReq;
			palRd <= cpuReq & ~cpuWe & palHit;
		end
	end

	// Latch zone and unmapped reads give zero
	assign cpuRdata = palRd ? palCpuRdata.raw : 16'h0000;

endmodule

/* neoPkg.sv */
package neoPkg;

	// One palette word with two decodings
	typedef union packed {
		// CPU view of the whole word
		logic [15:0] raw;
		// Colour view
		struct packed {
			logic dark;
			logic rLsb;
			logic gLsb;
			logic bLsb;
			logic [3:0] r;
			logic [3:0] g;
			logic [3:0] b;
		} fields;
	} PalWord;

	// Palette geometry
	localparam int PalIdxBits = 12;
	// Bank bit on top of the index
	localparam int PalAddrBits = 13;

	// Width of one output colour level
	localparam int ColorBits = 7;

	// Palette RAM block, word address bits 23:20
	localparam logic [3:0] PalZoneBase = 4'h4;

	// System latch block, word address bits 23:5 of 0x3A0000
	localparam logic [18:0] LatchZoneBase = 19'h1D000;

	// Latch entries in use
	localparam logic [2:0] LatchShadow = 3'd0;
	localparam logic [2:0] LatchPalBank = 3'd7;

	// Pixel FIFO entries, also the credits a source starts with
	localparam int PixFifoDepth = 4;

endpackage

/* neoVideo.sv */
`timescale 1ns/10ps

module neoVideo (
	input logic CLK_24M,
	input logic rst,
	input logic cpuReq,
	input logic cpuWe,
	input logic [23:1] cpuAddr,
	input logic [1:0] cpuBe,
	input logic [15:0] cpuWdata,
	output logic cpuAck,
	output logic [15:0] cpuRdata,
	input logic pixValid,
	input logic [neoPkg::PalIdxBits-1:0] pixIndex,
	output logic pixCredit,
	output logic serR,
	output logic serG,
	output logic serB,
	output logic serClk,
	output logic serLat
);

	logic palCpuEn;
	logic palCpuWe;
	logic [neoPkg::PalAddrBits-1:0] palCpuAddr;
	logic [1:0] palCpuBe;
	neoPkg::PalWord palCpuWdata;
	neoPkg::PalWord palCpuRdata;
	logic latchWe;
	logic [3:0] latchAddr;
	logic shadow;
	logic palBank;
	logic vidEn;
	logic [neoPkg::PalAddrBits-1:0] vidAddr;
	neoPkg::PalWord vidRdata;
	logic colValid;
	logic [neoPkg::ColorBits-1:0] colR;
	logic [neoPkg::ColorBits-1:0] colG;
	logic [neoPkg::ColorBits-1:0] colB;

	// Bus decoder in the C1 role
	cpuBus u_cpuBus (
		.CLK_24M(CLK_24M), .rst(rst), .cpuReq(cpuReq), .cpuWe(cpuWe), .cpuAddr(cpuAddr),
		.cpuBe(cpuBe), .cpuWdata(cpuWdata), .cpuAck(cpuAck), .cpuRdata(cpuRdata),
		.palCpuEn(palCpuEn), .palCpuWe(palCpuWe), .palCpuAddr(palCpuAddr),
		.palCpuBe(palCpuBe), .palCpuWdata(palCpuWdata), .latchWe(latchWe),
		.latchAddr(latchAddr), .palCpuRdata(palCpuRdata), .palBank(palBank)
	);

	sysLatch u_sysLatch (
		.CLK_24M(CLK_24M), .rst(rst), .latchWe(latchWe), .latchAddr(latchAddr),
		.shadow(shadow), .palBank(palBank)
	);

	palRam u_palRam (
		.CLK_24M(CLK_24M), .palCpuEn(palCpuEn), .palCpuWe(palCpuWe),
		.palCpuAddr(palCpuAddr), .palCpuBe(palCpuBe), .palCpuWdata(palCpuWdata),
		.palCpuRdata(palCpuRdata), .vidEn(vidEn), .vidAddr(vidAddr), .vidRdata(vidRdata)
	);

	// Pixel index to colour levels
	colorOut u_colorOut (
		.CLK_24M(CLK_24M), .rst(rst), .pixValid(pixValid), .pixIndex(pixIndex),
		.shadow(shadow), .palBank(palBank), .vidEn(vidEn), .vidAddr(vidAddr),
		.vidRdata(vidRdata), .colValid(colValid), .colR(colR), .colG(colG), .colB(colB)
	);

	serVideo u_serVideo (
		.CLK_24M(CLK_24M), .rst(rst), .colValid(colValid), .colR(colR), .colG(colG),
		.colB(colB), .pixCredit(pixCredit), .serR(serR), .serG(serG), .serB(serB),
		.serClk(serClk), .serLat(serLat)
	);

endmodule

/* palRam.sv */
`timescale 1ns/10ps

module palRam (
	input logic CLK_24M,
	input logic palCpuEn,
	input logic palCpuWe,
	input logic [neoPkg::PalAddrBits-1:0] palCpuAddr,
	input logic [1:0] palCpuBe,
	input neoPkg::PalWord palCpuWdata,
	output neoPkg::PalWord palCpuRdata,
	input logic vidEn,
	input logic [neoPkg::PalAddrBits-1:0] vidAddr,
	output neoPkg::PalWord vidRdata
);

	// Two banks, selected by the top address bit
	neoPkg::PalWord mem [2][2 ** neoPkg::PalIdxBits];

	// CPU port with byte lanes
	always_ff @(posedge CLK_24M) begin
		if (palCpuEn) begin
			if (palCpuWe && palCpuBe[1]) begin
				mem[palCpuAddr[12]][palCpuAddr[11:0]].raw[15:8] <= palCpuWdata.raw[15:8];
			end
			if (palCpuWe && palCpuBe[0]) begin
				mem[palCpuAddr[12]][palCpuAddr[11:0]].raw[7:0] <= palCpuWdata.raw[7:0];
			end
			palCpuRdata <= mem[palCpuAddr[12]][palCpuAddr[11:0]];
		end
	end

	// Video port, read only; a same-cycle CPU write shows up next time
	always_ff @(posedge CLK_24M) begin
		if (vidEn) begin
			vidRdata <= mem[vidAddr[12]][vidAddr[11:0]];
		end
	end

endmodule

/* serVideo.sv */
`timescale 1ns/10ps

module serVideo (
	input logic CLK_24M,
	input logic rst,
	input logic colValid,
	input logic [neoPkg::ColorBits-1:0] colR,
	input logic [neoPkg::ColorBits-1:0] colG,
	input logic [neoPkg::ColorBits-1:0] colB,
	output logic pixCredit,
	output logic serR,
	output logic serG,
	output logic serB,
	output logic serClk,
	output logic serLat
);

	logic [3*neoPkg::ColorBits-1:0] fifoMem [neoPkg::PixFifoDepth];
	logic [$clog2(neoPkg::PixFifoDepth)-1:0] wrPtr;
	logic [$clog2(neoPkg::PixFifoDepth)-1:0] rdPtr;
	logic [$clog2(neoPkg::PixFifoDepth):0] count;
	logic push;
	logic pop;
	logic busy;
	// 0..13 bit halves, 14 latch, 15 idle
	logic [3:0] step;
	logic [neoPkg::ColorBits-1:0] shR;
	logic [neoPkg::ColorBits-1:0] shG;
	logic [neoPkg::ColorBits-1:0] shB;

	// Credits keep the source from overfilling
	assign push = colValid && (count != neoPkg::PixFifoDepth);
	assign busy = (step != 4'hF);
	assign pop = !busy && (count != 0);
	assign pixCredit = pop;

	always_ff @(posedge CLK_24M) begin
		if (push) begin
			fifoMem[wrPtr] <= {colR, colG, colB};
		end
	end

	always_ff @(posedge CLK_24M) begin
		if (rst) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wrPtr <= wrPtr + 1'b1;
			end
			if (pop) begin
				rdPtr <= rdPtr + 1'b1;
			end
			count <= count + push - pop;
		end
	end

	// Sequence counter
	always_ff @(posedge CLK_24M) begin
		if (rst) begin
			step <= 4'hF;
		end else if (pop) begin
			step <= 4'h0;
		end else if (step == 2 * neoPkg::ColorBits) begin
			step <= 4'hF;
		end else if (busy) begin
			step <= step + 4'h1;
		end
	end

	// MSB first; next bit appears after the high half
	always_ff @(posedge CLK_24M) begin
		if (pop) begin
			{shR, shG, shB} <= fifoMem[rdPtr];
		end else if (busy && step[0]) begin
			shR <= shR << 1;
			shG <= shG << 1;
			shB <= shB << 1;
		end
	end

	assign serClk = busy & step[0];
	assign serLat = (step == 2 * neoPkg::ColorBits);
	assign serR = busy & shR[neoPkg::ColorBits-1];
	assign serG = busy & shG[neoPkg::ColorBits-1];
	assign serB = busy & shB[neoPkg::ColorBits-1];

endmodule

/* sources.f */
neoPkg.sv
cpuBus.sv
sysLatch.sv
palRam.sv
colorOut.sv
serVideo.sv
neoVideo.sv
tbNeoVideo.sv

/* sysLatch.sv */
`timescale 1ns/10ps

module sysLatch (
	input logic CLK_24M,
	input logic rst,
	input logic latchWe,
	input logic [3:0] latchAddr,
	output logic shadow,
	output logic palBank
);

	logic [7:0] latchBits;

	// Bit 4 of the address is the value, bits 3:1 pick the entry
	always_ff @(posedge CLK_24M) begin
		if (rst) begin
			latchBits <= 8'h00;
		end else if (latchWe) begin
			latchBits[latchAddr[2:0]] <= latchAddr[3];
		end
	end

	assign shadow = latchBits[neoPkg::LatchShadow];
	assign palBank = latchBits[neoPkg::LatchPalBank];

endmodule

/* tbNeoVideo.sv */
`timescale 1ns/10ps

module tbNeoVideo;

	localparam int ClkPeriod = 4;
	localparam int NumEntries = 16;
	localparam int BurstLong = 20;
	localparam int BurstShort = 8;
	localparam int NumPixels = BurstLong + 3 * BurstShort;
	localparam int NumBusOps = 3 * NumEntries + 11;
	localparam int WatchdogCycles = NumPixels * 15 + NumBusOps * 2 + 200;

	logic CLK_24M = 1'b0;
	logic rst;
	logic cpuReq;
	logic cpuWe;
	logic [23:1] cpuAddr;
	logic [1:0] cpuBe;
	logic [15:0] cpuWdata;
	logic [15:0] cpuRdata;
	logic cpuAck;
	logic pixValid;
	logic [11:0] pixIndex;
	logic pixCredit;
	logic serR;
	logic serG;
	logic serB;
	logic serClk;
	logic serLat;

	// Reference palette with two banks
	logic [15:0] palModel [2][4096];
	logic [11:0] idxList [NumEntries];
	logic [20:0] expQ [$];
	logic quiet = 1'b0;
	logic shadowOn = 1'b0;
	logic bankSel = 1'b0;
	logic prevClk;
	logic [6:0] rxR;
	logic [6:0] rxG;
	logic [6:0] rxB;
	int outstanding = 0;
	int rxCount = 0;
	int rises;
	int sinceLat;

	neoVideo u_neoVideo (
		.CLK_24M(CLK_24M), .rst(rst), .cpuReq(cpuReq), .cpuWe(cpuWe), .cpuAddr(cpuAddr),
		.cpuBe(cpuBe), .cpuWdata(cpuWdata), .cpuAck(cpuAck), .cpuRdata(cpuRdata),
		.pixValid(pixValid), .pixIndex(pixIndex), .pixCredit(pixCredit), .serR(serR),
		.serG(serG), .serB(serB), .serClk(serClk), .serLat(serLat)
	);

	always #(ClkPeriod / 2) CLK_24M = ~CLK_24M;

	task automatic endInFailure();
		$display("RESULT: FAIL");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic reportMismatch(input string name, input logic [31:0] expVal,
		input logic [31:0] actVal);
		$display("[FAIL] %s: expected %h, actual %h", name, expVal, actVal);
		endInFailure();
	endtask

	task automatic abortRun(input string what);
		$display("Error: %s", what);
		endInFailure();
	endtask

	// Upper part, lsb, inverted dark, zero; shadow halves the level
	function automatic logic [6:0] levelOf(input logic [3:0] upper, input logic lsb,
		input logic dark);
		int lvl;
		lvl = int'(upper) * 8 + int'(lsb) * 4 + (dark ? 0 : 2);
		if (shadowOn) begin
			lvl = lvl / 2;
		end
		return lvl[6:0];
	endfunction

	function automatic logic [20:0] pixelOf(input logic [15:0] w);
		return {levelOf(w[11:8], w[14], w[15]), levelOf(w[7:4], w[13], w[15]),
			levelOf(w[3:0], w[12], w[15])};
	endfunction

	// One request with the acknowledge expected on the next edge
	task automatic busAccess(input logic we, input logic [23:1] addr, input logic [1:0] be,
		input logic [15:0] wdata, output logic [15:0] rdata);
		@(posedge CLK_24M);
		cpuReq <= 1'b1;
		cpuWe <= we;
		cpuAddr <= addr;
		cpuBe <= be;
		cpuWdata <= wdata;
		@(posedge CLK_24M);
		cpuReq <= 1'b0;
		@(negedge CLK_24M);
		assert (cpuAck === 1'b1) else reportMismatch("bus acknowledge", 1, cpuAck);
		rdata = cpuRdata;
	endtask

	task automatic palWrite(input logic [11:0] idx, input logic [1:0] be,
		input logic [15:0] word);
		logic [15:0] rd;
		logic [15:0] old;
		old = palModel[bankSel][idx];
		busAccess(1'b1, {neoPkg::PalZoneBase, 7'd0, idx}, be, word, rd);
		palModel[bankSel][idx] = {be[1] ? word[15:8] : old[15:8], be[0] ? word[7:0] : old[7:0]};
	endtask

	task automatic palCheck(input logic [11:0] idx, input string name);
		logic [15:0] rd;
		busAccess(1'b0, {neoPkg::PalZoneBase, 7'd0, idx}, 2'b11, 16'h0000, rd);
		assert (rd === palModel[bankSel][idx])
			else reportMismatch(name, palModel[bankSel][idx], rd);
	endtask

	// Address-only write with the value in bit 4
	task automatic setLatch(input logic [2:0] entry, input logic value);
		logic [15:0] rd;
		busAccess(1'b1, {neoPkg::LatchZoneBase, value, entry}, 2'b11, 16'h0000, rd);
		if (entry == neoPkg::LatchShadow) begin
			shadowOn = value;
		end else if (entry == neoPkg::LatchPalBank) begin
			bankSel = value;
		end
	endtask

	// Sends whenever a credit is left and then waits for the serial side to drain
	task automatic sendBurst(input int n);
		int sent;
		logic [11:0] idx;
		sent = 0;
		while (sent < n) begin
			@(posedge CLK_24M);
			if (outstanding < neoPkg::PixFifoDepth) begin
				idx = idxList[$urandom % NumEntries];
				pixValid <= 1'b1;
				pixIndex <= idx;
				expQ.push_back(pixelOf(palModel[bankSel][idx]));
				sent++;
			end else begin
				pixValid <= 1'b0;
			end
		end
		@(posedge CLK_24M);
		pixValid <= 1'b0;
		while (expQ.size() != 0) begin
			@(posedge CLK_24M);
		end
	endtask

	// Credit count and serial receiver sampled mid-cycle
	always @(negedge CLK_24M) begin
		if (rst) begin
			outstanding = 0;
			rises = 0;
			sinceLat = 100;
			prevClk = 1'b0;
		end else begin
			outstanding = outstanding + int'(pixValid) - int'(pixCredit);
			sinceLat++;
			if (serClk && !prevClk) begin
				rxR = {rxR[5:0], serR};
				rxG = {rxG[5:0], serG};
				rxB = {rxB[5:0], serB};
				rises++;
			end
			prevClk = serClk;
			if (serLat) begin
				assert (rises == 7) else reportMismatch("serClk rises per pixel", 7, rises);
				assert (sinceLat >= 15) else abortRun("two serLat pulses closer than 15 cycles");
				assert (expQ.size() != 0) else abortRun("serLat without a pixel in flight");
				assert ({rxR, rxG, rxB} === expQ[0])
					else reportMismatch($sformatf("pixel %0d", rxCount), expQ[0], {rxR, rxG, rxB});
				void'(expQ.pop_front());
				rxCount++;
				rises = 0;
				sinceLat = 0;
			end
		end
	end

	assert property (@(posedge CLK_24M)
		quiet |-> !(cpuAck || pixCredit || serClk || serLat || serR || serG || serB))
		else abortRun("an output was active during reset or before any traffic");
	assert property (@(posedge CLK_24M) disable iff (rst) cpuAck == $past(cpuReq))
		else abortRun("cpuAck did not follow cpuReq by exactly one cycle");
	assert property (@(posedge CLK_24M) disable iff (rst)
		outstanding >= 0 && outstanding <= neoPkg::PixFifoDepth)
		else abortRun("pixels in flight went outside the credit range");

	initial begin
		#(WatchdogCycles * ClkPeriod);
		$display("Timeout: run still going after %0d cycles", WatchdogCycles);
		endInFailure();
	end

	initial begin
		logic [15:0] rd;
		void'($urandom(37597));
		rst = 1'b1;
		cpuReq = 1'b0;
		cpuWe = 1'b0;
		cpuAddr = '0;
		cpuBe = 2'b00;
		cpuWdata = 16'h0000;
		pixValid = 1'b0;
		pixIndex = '0;
		@(posedge CLK_24M);
		quiet <= 1'b1;
		repeat (3) @(posedge CLK_24M);
		rst <= 1'b0;
		repeat (8) @(posedge CLK_24M);
		quiet <= 1'b0;
		// Full words first with the dark bit alternating
		for (int i = 0; i < NumEntries; i++) begin
			idxList[i] = 12'($urandom);
			palWrite(idxList[i], 2'b11, {i[0], 15'($urandom)});
		end
		palWrite(idxList[0], 2'b10, 16'($urandom));
		palCheck(idxList[0], "upper byte merge");
		palWrite(idxList[0], 2'b01, 16'($urandom));
		palCheck(idxList[0], "lower byte merge");
		for (int i = 0; i < NumEntries; i++) begin
			palCheck(idxList[i], $sformatf("palette readback %0d", i));
		end
		busAccess(1'b0, {4'h1, 19'h00000}, 2'b11, 16'h0000, rd);
		assert (rd === 16'h0000) else reportMismatch("unmapped read", 0, rd);
		busAccess(1'b0, {neoPkg::LatchZoneBase, 4'h0}, 2'b11, 16'h0000, rd);
		assert (rd === 16'h0000) else reportMismatch("latch zone read", 0, rd);
		sendBurst(BurstLong);
		// Shadow on and then off
		setLatch(neoPkg::LatchShadow, 1'b1);
		sendBurst(BurstShort);
		setLatch(neoPkg::LatchShadow, 1'b0);
		// Second bank gets its own words
		setLatch(neoPkg::LatchPalBank, 1'b1);
		for (int i = 0; i < NumEntries; i++) begin
			palWrite(idxList[i], 2'b11, 16'($urandom));
		end
		sendBurst(BurstShort);
		setLatch(neoPkg::LatchPalBank, 1'b0);
		palCheck(idxList[0], "bank 0 after clear");
		sendBurst(BurstShort);
		// One idle pixel period, then every credit must be back
		repeat (16) @(posedge CLK_24M);
		assert (outstanding == 0)
			else reportMismatch("credits outstanding at the end", 0, outstanding);
		$display("RESULT: PASS");
		$finish;
	end

endmodule
